// File: hw/mul_pkg.sv
// Shared types for the RV32M multiply cluster; ids are 4 bits, so at most 16 tags in flight
package mul_pkg;

    //////////////////////////////
    // Plain vector types
    //////////////////////////////

    typedef logic [31:0] word_t;      // One rs1/rs2/rd word
    typedef logic [3:0]  instr_id_t;  // Tag from the core, returned with the result

    //////////////////////////////
    // Operation code
    //////////////////////////////

    // Low two bits of funct3 for the multiply group
    typedef enum logic [1:0] {
        MUL_OP_MUL    = 2'b00,  // Low 32 bits, sign irrelevant
        MUL_OP_MULH   = 2'b01,  // High, signed x signed
        MUL_OP_MULHSU = 2'b10,  // High, signed x unsigned
        MUL_OP_MULHU  = 2'b11   // High, unsigned x unsigned
    } mul_op_t;

    //////////////////////////////
    // Request and result
    //////////////////////////////

    // Issue side request, 70 bits
    typedef struct packed {
        word_t     rs1;
        word_t     rs2;
        mul_op_t   op;
        instr_id_t id;
    } mul_req_t;

    // Writeback result, 36 bits
    typedef struct packed {
        word_t     rd;   // Selected half of the product
        instr_id_t id;   // Same id the request carried
    } mul_res_t;

    //////////////////////////////
    // Issue queue state
    //////////////////////////////

    // Only the issue queue tracks this
    typedef enum logic [1:0] {
        FIFO_INIT,     // Held in or just out of reset, no pushes yet
        FIFO_EMPTY,
        FIFO_PARTIAL,
        FIFO_FULL
    } fifo_state_t;

endpackage

// File: hw/mul_issue_queue.sv
// Request FIFO, FIFO_DEPTH a power of two >= 2; an entry pops one cycle after it lands, no bypass
module mul_issue_queue #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  mul_pkg::mul_req_t in_req,
    input  logic              in_valid,
    output logic              in_ready,
    output mul_pkg::mul_req_t out_req,
    output logic              out_valid,
    input  logic              out_ready
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;  // Must reach FIFO_DEPTH

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t FULL_CNT = cnt_t'(FIFO_DEPTH);

    mul_pkg::mul_req_t    mem [FIFO_DEPTH];  // Payload storage
    ptr_t                 wr_ptr;
    ptr_t                 rd_ptr;
    cnt_t                 count;       // Entries stored
    cnt_t                 count_next;
    cnt_t                 avail;       // Entries old enough to pop
    logic                 pushed_q;    // Push of last cycle, not yet visible
    logic                 push;
    logic                 pop;
    mul_pkg::fifo_state_t state;
    mul_pkg::fifo_state_t state_next;

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // Full queue still takes a request on the cycle it pops one
    assign in_ready = (state == mul_pkg::FIFO_EMPTY) | (state == mul_pkg::FIFO_PARTIAL)
                    | ((state == mul_pkg::FIFO_FULL) & pop);

    assign out_valid = (avail != '0);
    assign out_req   = mem[rd_ptr];  // Oldest entry

    assign count_next = count + cnt_t'(push) - cnt_t'(pop);

    always_comb begin
        if (count_next == '0)
            state_next = mul_pkg::FIFO_EMPTY;
        else if (count_next == FULL_CNT)
            state_next = mul_pkg::FIFO_FULL;
        else
            state_next = mul_pkg::FIFO_PARTIAL;
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_req;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            avail    <= '0;
            pushed_q <= 1'b0;
            state    <= mul_pkg::FIFO_INIT;  // Keeps in_ready low
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_DEPTH
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count    <= count_next;
            avail    <= avail + cnt_t'(pushed_q) - cnt_t'(pop);  // Lags count by one push
            pushed_q <= push;
            state    <= state_next;
        end
    end

endmodule

// File: hw/mul_unit.sv
// Three-stage RV32M multiplier; holds three requests, no flush, results leave in issue order
module mul_unit (
    input  logic              clk,
    input  logic              rst,
    input  mul_pkg::mul_req_t issue_req,
    input  logic              issue_valid,
    output logic              issue_ready,
    output mul_pkg::mul_res_t wb_res,
    output logic              wb_valid,
    input  logic              wb_accepted
);

    typedef logic signed [32:0] opnd_ext_t;  // Operand plus sign or zero bit
    typedef logic signed [65:0] product_t;   // Full 33x33 product

    logic [2:0]          valid;    // Per stage occupancy
    logic [2:0]          advance;  // Stage may load this edge
    logic                issue;
    logic                rs1_signed;
    logic                rs2_signed;
    opnd_ext_t           rs1_ext;
    opnd_ext_t           rs2_ext;

    // Stage 1 registers
    opnd_ext_t           rs1_s1;
    opnd_ext_t           rs2_s1;
    logic                high_s1;
    mul_pkg::instr_id_t  id_s1;

    // Stage 2 registers
    product_t            prod_s2;
    logic                high_s2;
    mul_pkg::instr_id_t  id_s2;

    // Stage 3 registers
    product_t            prod_s3;
    logic                high_s3;
    mul_pkg::instr_id_t  id_s3;

    //////////////////////////////
    // Stall chain
    //////////////////////////////

    // A stage loads when it is empty or its contents move on
    assign advance[2] = wb_accepted | ~valid[2];
    assign advance[1] = advance[2] | ~valid[1];
    assign advance[0] = advance[1] | ~valid[0];

    // Some stage free, or the last one leaving this edge
    assign issue_ready = advance[0];
    assign issue       = issue_valid & issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (advance[0])
                valid[0] <= issue_valid;
            if (advance[1])
                valid[1] <= valid[0];
            if (advance[2])
                valid[2] <= valid[1];
        end
    end

    //////////////////////////////
    // Operand extension
    //////////////////////////////

    // Sign rules per funct3; MUL low half comes out the same either way
    assign rs1_signed = (issue_req.op == mul_pkg::MUL_OP_MULH)
                      | (issue_req.op == mul_pkg::MUL_OP_MULHSU);
    assign rs2_signed = (issue_req.op == mul_pkg::MUL_OP_MUL)
                      | (issue_req.op == mul_pkg::MUL_OP_MULH);

    assign rs1_ext = {issue_req.rs1[31] & rs1_signed, issue_req.rs1};
    assign rs2_ext = {issue_req.rs2[31] & rs2_signed, issue_req.rs2};

    //////////////////////////////
    // Datapath
    //////////////////////////////

    // Stage 1, loaded only on a real issue
    always_ff @(posedge clk) begin
        if (issue) begin
            rs1_s1  <= rs1_ext;
            rs2_s1  <= rs2_ext;
            high_s1 <= (issue_req.op != mul_pkg::MUL_OP_MUL);  // Any H op wants [63:32]
            id_s1   <= issue_req.id;
        end
    end

    // Stage 2, signed multiply of the extended operands
    always_ff @(posedge clk) begin
        if (advance[1]) begin
            prod_s2 <= rs1_s1 * rs2_s1;
            high_s2 <= high_s1;
            id_s2   <= id_s1;
        end
    end

    // Stage 3, held while writeback stalls
    always_ff @(posedge clk) begin
        if (advance[2]) begin
            prod_s3 <= prod_s2;
            high_s3 <= high_s2;
            id_s3   <= id_s2;
        end
    end

    //////////////////////////////
    // Writeback side
    //////////////////////////////

    assign wb_valid  = valid[2];
    assign wb_res.rd = high_s3 ? prod_s3[63:32] : prod_s3[31:0];  // Bits 65:64 are sign only
    assign wb_res.id = id_s3;

endmodule

// File: hw/mul_wb_buffer.sv
// Two-entry writeback skid buffer; out_accepted is only meaningful while out_valid is high
module mul_wb_buffer (
    input  logic              clk,
    input  logic              rst,
    input  mul_pkg::mul_res_t in_res,
    input  logic              in_valid,
    output logic              in_accepted,
    output mul_pkg::mul_res_t out_res,
    output logic              out_valid,
    input  logic              out_accepted
);

    mul_pkg::mul_res_t main_res;    // Front result, seen by writeback
    mul_pkg::mul_res_t skid_res;    // Second result while front waits
    logic              main_valid;
    logic              skid_valid;  // Only set while main_valid is set
    logic              push;
    logic              pop;

    // Registered, so consumer stalls never reach the multiplier combinationally
    assign in_accepted = ~skid_valid;

    assign push = in_valid & in_accepted;
    assign pop  = main_valid & out_accepted;

    assign out_valid = main_valid;
    assign out_res   = main_res;

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (~main_valid | pop)
                main_valid <= skid_valid | push;  // Refill from skid first
            if (skid_valid & pop)
                skid_valid <= 1'b0;  // Skid moves to main
            else if (push & main_valid & ~pop)
                skid_valid <= 1'b1;  // Front is stuck, park the new one
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (~main_valid | pop) begin
            if (skid_valid)
                main_res <= skid_res;
            else if (push)
                main_res <= in_res;
        end
        if (push & main_valid & ~pop)
            skid_res <= in_res;
    end

endmodule

// File: hw/mul_cluster.sv
// RV32M multiply cluster top; in-order results, req_ready low in reset and one cycle after
module mul_cluster #(
    parameter int FIFO_DEPTH = 4  // Issue queue entries, power of two >= 2
) (
    input  logic              clk,
    input  logic              rst,

    // Issue side, valid/ready
    input  mul_pkg::mul_req_t req,
    input  logic              req_valid,
    output logic              req_ready,

    // Writeback side, valid/accepted
    output mul_pkg::mul_res_t res,
    output logic              res_valid,
    input  logic              res_accepted
);

    mul_pkg::mul_req_t q_req;             // Queue head
    logic              q_valid;
    logic              issue_ready;       // Pipeline can take q_req
    mul_pkg::mul_res_t mul_res;           // Stage 3 result
    logic              mul_res_valid;
    logic              mul_res_accepted;  // Skid slot free

    //////////////////////////////
    // Issue queue
    //////////////////////////////

    mul_issue_queue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) mul_issue_queue_i (
        .clk       (clk),
        .rst       (rst),
        .in_req    (req),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .out_req   (q_req),
        .out_valid (q_valid),
        .out_ready (issue_ready)
    );

    // Multiplier pipeline
    mul_unit mul_unit_i (
        .clk         (clk),
        .rst         (rst),
        .issue_req   (q_req),
        .issue_valid (q_valid),
        .issue_ready (issue_ready),
        .wb_res      (mul_res),
        .wb_valid    (mul_res_valid),
        .wb_accepted (mul_res_accepted)
    );

    // Writeback buffer
    mul_wb_buffer mul_wb_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .in_res       (mul_res),
        .in_valid     (mul_res_valid),
        .in_accepted  (mul_res_accepted),
        .out_res      (res),
        .out_valid    (res_valid),
        .out_accepted (res_accepted)
    );

endmodule

// File: bench/tb_clock.sv
// Free-running testbench clock, period 40; rst is high for the first 4 rising edges
module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;  // Full period 40
    localparam int RESET_EDGES = 4;

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

    // Released on a rising edge, like any other DUT input
    initial begin
        rst = 1'b1;
        repeat (RESET_EDGES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: bench/tb_mul_cluster.sv
// Directed tests of mul_cluster with FIFO_DEPTH 4; outputs are sampled on the falling edge
module tb_mul_cluster;

    localparam int N_CORNER = 64;  // 4 ops x 4 x 4 corner operands
    localparam int N_LAT    = 1;
    localparam int N_STREAM = 40;
    localparam int N_BP     = 12;  // 9 fill the cluster, 3 wait
    localparam int N_RAND   = 30;
    localparam int TIMEOUT_CYCLES = (N_CORNER + N_LAT + N_STREAM + N_BP + N_RAND) * 20 + 200;

    logic              clk;
    logic              rst;
    mul_pkg::mul_req_t req;
    logic              req_valid;
    logic              req_ready;
    mul_pkg::mul_res_t res;
    logic              res_valid;
    logic              res_accepted;

    mul_pkg::mul_req_t  send_q[$];   // Still to be offered, front is on req
    mul_pkg::mul_res_t  exp_q[$];    // Owed by the DUT, oldest first
    mul_pkg::instr_id_t next_id;
    mul_pkg::mul_res_t  hold_res;    // Front result last seen unaccepted
    logic               hold_valid;
    logic               last_ready;  // req_ready at the latest sample
    int                 seed;
    int                 errors;
    int                 tests_run;
    int                 accepted_cnt;
    int                 result_cnt;
    int                 cycle_cnt;

    tb_clock tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    mul_cluster #(
        .FIFO_DEPTH (4)
    ) mul_cluster_i (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .res          (res),
        .res_valid    (res_valid),
        .res_accepted (res_accepted)
    );

    //////////////////////////////
    // Model and compare tasks
    //////////////////////////////

    // RV32M result from 64-bit products of sign or zero extended operands
    function automatic mul_pkg::mul_res_t expected_result(input mul_pkg::mul_req_t r);
        logic [63:0]       a;
        logic [63:0]       b;
        logic [63:0]       p;
        mul_pkg::mul_res_t e;
        a = {32'h0, r.rs1};
        b = {32'h0, r.rs2};
        if (r.op == mul_pkg::MUL_OP_MULH || r.op == mul_pkg::MUL_OP_MULHSU)
            a = {{32{r.rs1[31]}}, r.rs1};  // rs1 signed
        if (r.op == mul_pkg::MUL_OP_MULH)
            b = {{32{r.rs2[31]}}, r.rs2};  // rs2 signed only for MULH here
        p    = a * b;                      // Exact mod 2^64
        e.rd = (r.op == mul_pkg::MUL_OP_MUL) ? p[31:0] : p[63:32];
        e.id = r.id;
        return e;
    endfunction

    task automatic check_word(input mul_pkg::word_t got, input mul_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_id(input mul_pkg::instr_id_t got, input mul_pkg::instr_id_t exp,
                            input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // Message says what went wrong when got differs from exp
    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("%s, at time %0t", msg, $time);
            errors++;
        end
    endtask

    //////////////////////////////
    // Cycle engine
    //////////////////////////////

    // Falling edge view of what the next rising edge will transfer
    task automatic sample_handshakes();
        mul_pkg::mul_res_t e;
        last_ready = req_ready;
        if (req_valid && req_ready) begin
            exp_q.push_back(expected_result(req));
            send_q.delete(0);
            accepted_cnt++;
        end
        if (hold_valid) begin  // Unaccepted result must not move
            check_flag(res_valid, 1'b1, "res_valid dropped before its result was accepted");
            check_word(res.rd, hold_res.rd, "held rd");
            check_id(res.id, hold_res.id, "held id");
        end
        hold_valid = res_valid && !res_accepted;
        hold_res   = res;
        if (res_valid && res_accepted) begin
            result_cnt++;  // Every popped result, owed or not
            if (exp_q.size() == 0) begin
                check_flag(1'b1, 1'b0, "res_valid high with no pending result");
            end else begin
                e = exp_q.pop_front();
                check_word(res.rd, e.rd, "rd");
                check_id(res.id, e.id, "id");
            end
        end
    endtask

    // One clock: sample, then drive the next inputs on the rising edge
    task automatic tick(input logic accept);
        @(negedge clk);
        sample_handshakes();
        @(posedge clk);
        req_valid <= (send_q.size() != 0);
        if (send_q.size() != 0)
            req <= send_q[0];
        res_accepted <= accept;
    endtask

    task automatic run_until_drained(input logic random_accept);
        logic [31:0] r;
        while (send_q.size() != 0 || exp_q.size() != 0) begin
            r = $random(seed);
            tick(random_accept ? r[0] : 1'b1);
        end
    endtask

    task automatic random_request(output mul_pkg::mul_req_t r);
        r.rs1   = $random(seed);
        r.rs2   = $random(seed);
        r.op    = mul_pkg::mul_op_t'(2'($random(seed)));
        r.id    = next_id;
        next_id = next_id + 4'd1;
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%s finished with %0d errors", name, errors - err_start);
        tests_run++;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic reset_defaults();
        int err_start;
        err_start = errors;
        @(posedge clk);
        @(negedge clk);  // Still in reset
        check_flag(req_ready, 1'b0, "req_ready high during reset");
        wait (rst == 1'b0);
        @(posedge clk);  // Queue leaves its init state here
        @(negedge clk);
        check_flag(res_valid, 1'b0, "res_valid high after reset with no request");
        check_flag(req_ready, 1'b1, "req_ready low after reset");
        report_test("reset_defaults", err_start);
    endtask

    task automatic corner_operands();
        mul_pkg::word_t    corners [4] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h1};
        mul_pkg::mul_req_t r;
        int                err_start;
        err_start = errors;
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    r.rs1   = corners[i];
                    r.rs2   = corners[j];
                    r.op    = mul_pkg::mul_op_t'(2'(op));
                    r.id    = next_id;
                    next_id = next_id + 4'd1;
                    send_q.push_back(r);
                end
            end
            run_until_drained(1'b0);  // One op at a time
        end
        report_test("corner_operands", err_start);
    endtask

    task automatic issue_latency();
        mul_pkg::mul_req_t r;
        mul_pkg::mul_res_t e;
        int                err_start;
        int                edges;
        err_start = errors;
        r.rs1   = 32'hFFFF_FFFF;
        r.rs2   = 32'h8000_0000;
        r.op    = mul_pkg::MUL_OP_MULHSU;
        r.id    = next_id;
        next_id = next_id + 4'd1;
        e       = expected_result(r);
        @(posedge clk);
        req          <= r;
        req_valid    <= 1'b1;
        res_accepted <= 1'b1;
        @(negedge clk);
        check_flag(req_ready, 1'b1, "req_ready low on an idle cluster");
        @(posedge clk);  // Accepting edge
        req_valid <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!res_valid && edges < 20);
        check_flag(edges == 5, 1'b1,
                   $sformatf("res_valid rose %0d edges after acceptance, not 5", edges));
        check_word(res.rd, e.rd, "latency rd");
        check_id(res.id, e.id, "latency id");
        @(posedge clk);  // Popped, res_accepted is high
        report_test("issue_latency", err_start);
    endtask

    task automatic back_to_back_stream();
        mul_pkg::mul_req_t r;
        int                err_start;
        err_start = errors;
        repeat (N_STREAM) begin
            random_request(r);
            send_q.push_back(r);
        end
        run_until_drained(1'b0);
        report_test("back_to_back_stream", err_start);
    endtask

    task automatic backpressure_hold();
        mul_pkg::mul_req_t r;
        int                err_start;
        int                acc_start;
        int                res_start;
        err_start = errors;
        acc_start = accepted_cnt;
        res_start = result_cnt;
        repeat (N_BP) begin
            random_request(r);
            send_q.push_back(r);
        end
        repeat (30) tick(1'b0);  // Writeback stalled
        // Queue 4, pipeline 3, buffer 2
        check_flag(accepted_cnt - acc_start == 9, 1'b1,
                   $sformatf("%0d requests entered a stalled cluster that holds 9",
                             accepted_cnt - acc_start));
        check_flag(last_ready, 1'b0, "req_ready still high with every stage full");
        run_until_drained(1'b0);
        repeat (4) tick(1'b1);  // Room for a duplicate to show up
        check_flag(result_cnt - res_start == N_BP, 1'b1,
                   "results lost or duplicated after the stall was released");
        report_test("backpressure_hold", err_start);
    endtask

    task automatic random_acceptance();
        mul_pkg::mul_req_t r;
        int                err_start;
        err_start = errors;
        repeat (N_RAND) begin
            random_request(r);
            send_q.push_back(r);
        end
        run_until_drained(1'b1);
        report_test("random_acceptance", err_start);
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////

    // Hang guard sized from the request count
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        req          = '0;
        req_valid    = 1'b0;
        res_accepted = 1'b0;
        next_id      = '0;
        hold_res     = '0;
        hold_valid   = 1'b0;
        last_ready   = 1'b0;
        seed         = 61;
        errors       = 0;
        tests_run    = 0;
        accepted_cnt = 0;
        result_cnt   = 0;
        cycle_cnt    = 0;

        reset_defaults();
        corner_operands();
        issue_latency();
        back_to_back_stream();
        backpressure_hold();
        random_acceptance();
        repeat (8) tick(1'b1);  // Catches stray results

        $display("Summary: %0d tests, %0d requests, %0d results, %0d errors",
                 tests_run, accepted_cnt, result_cnt, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: filelist.f
hw/mul_pkg.sv
hw/mul_issue_queue.sv
hw/mul_unit.sv
hw/mul_wb_buffer.sv
hw/mul_cluster.sv
bench/tb_clock.sv
bench/tb_mul_cluster.sv

// File: run.sh
#!/bin/sh
# Build and run the mul_cluster testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f filelist.f \
    --top-module tb_mul_cluster \
    -o sim_mul_cluster

./obj_dir/sim_mul_cluster > sim.log 2>&1
cat sim.log

grep -q "^Done: no errors$" sim.log
echo "Simulation passed"
